//--- build.f
source/fifo_pkg.sv
source/apb_pkg.sv
source/synchronizer.sv
source/async_fifo.sv
source/apb_ctrl_fsm.sv
source/drain_timer.sv
source/mailbox_regs.sv
source/cdc_mailbox_top.sv
test/tb_cdc_mailbox.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the mailbox testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_cdc_mailbox -f build.f \
    -Mdir obj_dir -o sim_mailbox
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_mailbox)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

//--- source/apb_ctrl_fsm.sv
module apb_ctrl_fsm (
    input  logic                 rd_clk,
    input  logic                 r_rst_n,
    input  apb_pkg::apb_req_t    apb_req,
    output apb_pkg::apb_rsp_t    apb_rsp,
    output apb_pkg::reg_access_t reg_acc,
    output logic                 rd_pop,
    input  logic [31:0]          rdata,
    input  logic                 err
);

    import apb_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        RESPOND
    } state_t;

    state_t state, state_nxt;

    always_ff @(posedge rd_clk) begin
        if (!r_rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ************************************************************
    // Transfer sequencing
    // ************************************************************

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (apb_req.psel && !apb_req.penable) begin
                    state_nxt = ACCESS;  // Setup cycle seen on the bus
                end else if (apb_req.psel) begin
                    // Access phase without a setup we saw, e.g. just out of reset
                    state_nxt = SETUP;
                end
            end
            SETUP:   state_nxt = ACCESS;
            ACCESS:  state_nxt = RESPOND;
            RESPOND: state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // ************************************************************
    // Outputs
    // ************************************************************

    always_comb begin
        reg_acc = '0;
        rd_pop  = 1'b0;
        apb_rsp = '0;

        if (state == ACCESS) begin
            reg_acc.strobe = 1'b1;
            reg_acc.write  = apb_req.pwrite;
            reg_acc.addr   = apb_req.paddr;
            reg_acc.wdata  = apb_req.pwdata;
            rd_pop         = !apb_req.pwrite && (apb_req.paddr == ADDR_DATA);
        end

        if (state == RESPOND) begin
            apb_rsp.pready  = 1'b1;  // One fixed wait state
            apb_rsp.prdata  = rdata;
            apb_rsp.pslverr = err;
        end
    end

endmodule

//--- source/apb_pkg.sv
package apb_pkg;

    localparam int APB_ADDR_W = 4;
    localparam int APB_DATA_W = 32;

    // ************************************************************
    // Bus side
    // ************************************************************

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    // ************************************************************
    // Internal register access, one cycle per transfer
    // ************************************************************

    typedef struct packed {
        logic                  strobe;
        logic                  write;
        logic [APB_ADDR_W-1:0] addr;
        logic [APB_DATA_W-1:0] wdata;
    } reg_access_t;

    localparam logic [APB_ADDR_W-1:0] ADDR_DATA   = 4'h0;
    localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 4'h4;
    localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 4'h8;
    localparam logic [APB_ADDR_W-1:0] ADDR_IRQ    = 4'hC;

endpackage

//--- source/async_fifo.sv
module async_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                      wr_clk,
    input  logic                      w_rst_n,
    input  logic                      wr_en,
    input  logic [DATA_WIDTH-1:0]     wr_data,
    output logic                      full,
    input  logic                      rd_clk,
    input  logic                      r_rst_n,
    input  logic                      rd_pop,
    output logic [DATA_WIDTH-1:0]     rd_data,
    output logic                      rd_valid,
    output fifo_pkg::fifo_rd_status_t rd_status
);

    import fifo_pkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);
    localparam int PTR_W  = ADDR_W + 1;  // Extra wrap bit

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_bin, wr_gray;
    logic [PTR_W-1:0] rd_bin, rd_gray;
    logic [PTR_W-1:0] wr_gray_rd, rd_gray_wr;  // Gray pointers after crossing
    logic [PTR_W-1:0] wr_bin_rd, rd_bin_wr;
    logic [PTR_W-1:0] rd_fill;
    logic             push_ok;
    logic             pop_ok;
    logic             empty;

    function automatic logic [PTR_W-1:0] bin2gray(input logic [PTR_W-1:0] b);
        return b ^ (b >> 1);
    endfunction

    function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] g);
        logic [PTR_W-1:0] b;
        b[PTR_W-1] = g[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // ************************************************************
    // Write domain
    // ************************************************************

    assign push_ok = wr_en && !full;

    always_ff @(posedge wr_clk) begin
        if (!w_rst_n) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else if (push_ok) begin
            wr_bin  <= wr_bin + 1'b1;
            wr_gray <= bin2gray(wr_bin + 1'b1);  // Registered, no glitch into the crossing
        end
    end

    always_ff @(posedge wr_clk) begin
        if (push_ok) begin
            mem[wr_bin[ADDR_W-1:0]] <= wr_data;
        end
    end

    synchronizer #(.WIDTH(PTR_W)) u_sync_rd2wr (
        .clk_dest (wr_clk),
        .rst_n    (w_rst_n),
        .data_in  (rd_gray),
        .data_out (rd_gray_wr)
    );

    assign rd_bin_wr = gray2bin(rd_gray_wr);
    assign full      = wr_bin == {~rd_bin_wr[ADDR_W], rd_bin_wr[ADDR_W-1:0]};  // Same slot, other lap

    // ************************************************************
    // Read domain
    // ************************************************************

    synchronizer #(.WIDTH(PTR_W)) u_sync_wr2rd (
        .clk_dest (rd_clk),
        .rst_n    (r_rst_n),
        .data_in  (wr_gray),
        .data_out (wr_gray_rd)
    );

    assign wr_bin_rd = gray2bin(wr_gray_rd);
    assign empty     = rd_bin == wr_bin_rd;
    assign pop_ok    = rd_pop && !empty;

    always_ff @(posedge rd_clk) begin
        if (!r_rst_n) begin
            rd_bin   <= '0;
            rd_gray  <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= pop_ok;
            if (pop_ok) begin
                rd_bin  <= rd_bin + 1'b1;
                rd_gray <= bin2gray(rd_bin + 1'b1);
            end
        end
    end

    always_ff @(posedge rd_clk) begin
        if (pop_ok) begin
            rd_data <= mem[rd_bin[ADDR_W-1:0]];
        end
    end

    assign rd_fill         = wr_bin_rd - rd_bin;  // Wraps correctly with the lap bit
    assign rd_status.empty = empty;
    assign rd_status.level = LEVEL_BITS'(rd_fill);

endmodule

//--- source/cdc_mailbox_top.sv
module cdc_mailbox_top #(
    parameter int DATA_WIDTH = 8,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                  wr_clk,
    input  logic                  w_rst_n,
    input  logic                  wr_en,
    input  logic [DATA_WIDTH-1:0] wr_data,
    output logic                  full,
    input  logic                  rd_clk,
    input  logic                  r_rst_n,
    input  apb_pkg::apb_req_t     apb_req,
    output apb_pkg::apb_rsp_t     apb_rsp,
    output logic                  irq
);

    import apb_pkg::*;
    import fifo_pkg::*;

    reg_access_t           reg_acc;
    fifo_rd_status_t       rd_status;
    timer_cfg_t            cfg;
    logic                  rd_pop;
    logic [DATA_WIDTH-1:0] rd_data;
    logic                  rd_valid;
    logic [31:0]           rdata;
    logic                  err;
    logic                  expire;

    async_fifo #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .wr_clk    (wr_clk),
        .w_rst_n   (w_rst_n),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .full      (full),
        .rd_clk    (rd_clk),
        .r_rst_n   (r_rst_n),
        .rd_pop    (rd_pop),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .rd_status (rd_status)
    );

    apb_ctrl_fsm u_apb_fsm (
        .rd_clk  (rd_clk),
        .r_rst_n (r_rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .reg_acc (reg_acc),
        .rd_pop  (rd_pop),
        .rdata   (rdata),
        .err     (err)
    );

    drain_timer u_timer (
        .rd_clk    (rd_clk),
        .r_rst_n   (r_rst_n),
        .rd_status (rd_status),
        .rd_valid  (rd_valid),
        .cfg       (cfg),
        .expire    (expire)
    );

    mailbox_regs #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_regs (
        .rd_clk    (rd_clk),
        .r_rst_n   (r_rst_n),
        .reg_acc   (reg_acc),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .rd_status (rd_status),
        .expire    (expire),
        .cfg       (cfg),
        .rdata     (rdata),
        .err       (err),
        .irq       (irq)
    );

endmodule

//--- source/drain_timer.sv
module drain_timer (
    input  logic                      rd_clk,
    input  logic                      r_rst_n,
    input  fifo_pkg::fifo_rd_status_t rd_status,
    input  logic                      rd_valid,
    input  fifo_pkg::timer_cfg_t      cfg,
    output logic                      expire
);

    logic [15:0] count;
    logic        fired;  // Expiry already reported for this wait
    logic        clear;

    // Any read, an empty FIFO or a zero threshold restarts the wait
    assign clear = rd_valid || rd_status.empty || (cfg.threshold == '0);

    always_ff @(posedge rd_clk) begin
        if (!r_rst_n) begin
            count <= '0;
            fired <= 1'b0;
        end else if (clear) begin
            count <= '0;
            fired <= 1'b0;
        end else begin
            if (count < cfg.threshold) begin
                count <= count + 1'b1;  // Holds once at the threshold
            end
            if (expire) begin
                fired <= 1'b1;
            end
        end
    end

    assign expire = !clear && !fired && (count >= cfg.threshold);

endmodule

//--- source/fifo_pkg.sv
package fifo_pkg;

    // ************************************************************
    // Read-side view of the FIFO
    // ************************************************************

    localparam int LEVEL_BITS = 8;  // Covers depths up to 128

    typedef struct packed {
        logic                  empty;
        logic [LEVEL_BITS-1:0] level;  // Unread words seen from rd_clk
    } fifo_rd_status_t;

    // ************************************************************
    // Drain timer setup, held in the CTRL register
    // ************************************************************

    typedef struct packed {
        logic [15:0] threshold;  // Zero keeps the timer idle
        logic        irq_en;
    } timer_cfg_t;

endpackage

//--- source/mailbox_regs.sv
module mailbox_regs #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                      rd_clk,
    input  logic                      r_rst_n,
    input  apb_pkg::reg_access_t      reg_acc,
    input  logic [DATA_WIDTH-1:0]     rd_data,
    input  logic                      rd_valid,
    input  fifo_pkg::fifo_rd_status_t rd_status,
    input  logic                      expire,
    output fifo_pkg::timer_cfg_t      cfg,
    output logic [31:0]               rdata,
    output logic                      err,
    output logic                      irq
);

    import apb_pkg::*;
    import fifo_pkg::*;

    logic        irq_flag;
    logic        ctrl_wr;
    logic        irq_wr;
    logic        addr_hit;
    logic        data_sel;  // Last access was a DATA read
    logic        err_q;
    logic [31:0] word_nxt;
    logic [31:0] word_q;

    assign ctrl_wr = reg_acc.strobe && reg_acc.write && (reg_acc.addr == ADDR_CTRL);
    assign irq_wr  = reg_acc.strobe && reg_acc.write && (reg_acc.addr == ADDR_IRQ);

    // ************************************************************
    // CTRL and sticky IRQ
    // ************************************************************

    always_ff @(posedge rd_clk) begin
        if (!r_rst_n) begin
            cfg      <= '0;
            irq_flag <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                cfg.threshold <= reg_acc.wdata[15:0];
                cfg.irq_en    <= reg_acc.wdata[16];
            end
            if (expire) begin
                irq_flag <= 1'b1;  // New expiry beats a clear in the same cycle
            end else if (irq_wr && reg_acc.wdata[0]) begin
                irq_flag <= 1'b0;
            end
        end
    end

    assign irq = irq_flag && cfg.irq_en;

    // ************************************************************
    // Read word
    // ************************************************************

    always_comb begin
        word_nxt = '0;
        addr_hit = 1'b1;
        case (reg_acc.addr)
            ADDR_DATA:   word_nxt = '0;  // Taken from the FIFO one cycle later
            ADDR_STATUS: begin
                word_nxt[0]                  = rd_status.empty;
                word_nxt[8 +: LEVEL_BITS]    = rd_status.level;
            end
            ADDR_CTRL:   word_nxt = {15'd0, cfg.irq_en, cfg.threshold};
            ADDR_IRQ:    word_nxt = {31'd0, irq_flag};
            default:     addr_hit = 1'b0;
        endcase
        if (reg_acc.write) begin
            word_nxt = '0;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (!r_rst_n) begin
            data_sel <= 1'b0;
            err_q    <= 1'b0;
        end else if (reg_acc.strobe) begin
            data_sel <= !reg_acc.write && (reg_acc.addr == ADDR_DATA);
            err_q    <= !addr_hit;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (reg_acc.strobe) begin
            word_q <= word_nxt;
        end
    end

    // Empty FIFO on a DATA read returns zero with an error
    assign rdata = data_sel ? (rd_valid ? 32'(rd_data) : 32'd0) : word_q;
    assign err   = data_sel ? !rd_valid : err_q;

endmodule

//--- source/synchronizer.sv
module synchronizer #(
    parameter int WIDTH = 5
) (
    input  logic             clk_dest,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out
);

    logic [WIDTH-1:0] meta;  // First stage, may go metastable

    always_ff @(posedge clk_dest) begin
        if (!rst_n) begin
            meta     <= '0;
            data_out <= '0;
        end else begin
            meta     <= data_in;
            data_out <= meta;
        end
    end

endmodule

//--- test/tb_cdc_mailbox.sv
module tb_cdc_mailbox;

    import apb_pkg::*;

    localparam int DATA_WIDTH  = 8;
    localparam int FIFO_DEPTH  = 16;
    localparam int RD_PERIOD   = 100;
    localparam int WR_PERIOD   = 130;
    localparam int IRQ_WAIT    = 20 + 4 + 3;  // Threshold, margin and write latency
    localparam int TEST_CYCLES = 16 + 40 + 80 + 20 + 250 + 120 + 200;  // Reset, then tests 1 to 6

    logic                  rd_clk = 1'b0;
    logic                  wr_clk = 1'b0;
    logic                  r_rst_n;
    logic                  w_rst_n;
    logic                  wr_en;
    logic [DATA_WIDTH-1:0] wr_data;
    logic                  full;
    logic                  irq;
    apb_req_t              apb_req;
    apb_rsp_t              apb_rsp;

    logic [DATA_WIDTH-1:0] model_q[$];  // Words the FIFO should hold, oldest first
    logic [31:0]           exp_rdata;
    logic                  exp_err;
    logic                  chk_data;
    logic                  chk_err;
    logic                  irq_masked;  // irq_en clear, so the pin stays low
    integer                seed;
    int                    error_count;
    int                    pass_tests;
    int                    fail_tests;

    always #(RD_PERIOD / 2) rd_clk = ~rd_clk;
    always #(WR_PERIOD / 2) wr_clk = ~wr_clk;

    cdc_mailbox_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .wr_clk  (wr_clk),
        .w_rst_n (w_rst_n),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .full    (full),
        .rd_clk  (rd_clk),
        .r_rst_n (r_rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .irq     (irq)
    );

    // ************************************************************
    // Bus and interrupt checks
    // ************************************************************

    reset_outputs: assert property (@(posedge rd_clk) $rose(r_rst_n) |->
        (!apb_rsp.pready && !apb_rsp.pslverr && !irq && !full && !dut.rd_valid))
    else begin
        error_count++;
        $display("[FAIL] reset state: pready 0x%h pslverr 0x%h irq 0x%h full 0x%h",
                 $sampled(apb_rsp.pready), $sampled(apb_rsp.pslverr), $sampled(irq),
                 $sampled(full));
    end

    ready_not_first: assert property (@(posedge rd_clk) disable iff (!r_rst_n)
        $rose(apb_req.penable) |-> !apb_rsp.pready)
    else begin
        error_count++;
        $display("[FAIL] pready: got 0x1, expected 0x0 in the first access cycle");
    end

    ready_second: assert property (@(posedge rd_clk) disable iff (!r_rst_n)
        $rose(apb_req.penable) |=> apb_rsp.pready)
    else begin
        error_count++;
        $display("[FAIL] pready: got 0x0, expected 0x1 in the second access cycle");
    end

    rdata_match: assert property (@(posedge rd_clk) disable iff (!r_rst_n)
        (apb_rsp.pready && chk_data) |-> (apb_rsp.prdata == exp_rdata))
    else begin
        error_count++;
        $display("[FAIL] prdata: got 0x%h, expected 0x%h",
                 $sampled(apb_rsp.prdata), $sampled(exp_rdata));
    end

    err_match: assert property (@(posedge rd_clk) disable iff (!r_rst_n)
        (apb_rsp.pready && chk_err) |-> (apb_rsp.pslverr == exp_err))
    else begin
        error_count++;
        $display("[FAIL] pslverr: got 0x%h, expected 0x%h",
                 $sampled(apb_rsp.pslverr), $sampled(exp_err));
    end

    irq_quiet: assert property (@(posedge rd_clk) disable iff (!r_rst_n) irq_masked |-> !irq)
    else begin
        error_count++;
        $display("[FAIL] irq: got 0x1, expected 0x0 with irq_en clear");
    end

    // ************************************************************
    // Stimulus tasks
    // ************************************************************

    function automatic logic [31:0] status_word(input int count);
        return {16'h0, 8'(count), 7'h0, count == 0};  // Level in 15:8, empty in bit 0
    endfunction

    task automatic bus_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
        int waits;
        @(negedge rd_clk);
        apb_req.psel    = 1'b1;  // Setup cycle
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge rd_clk);
        apb_req.penable = 1'b1;
        waits = 0;
        do begin
            @(negedge rd_clk);
            waits++;
        end while (!apb_rsp.pready && waits < 8);
        rdata = apb_rsp.prdata;
        if (!apb_rsp.pready) begin
            error_count++;
            $display("No pready for the transfer to 0x%h after %0d cycles", addr, waits);
        end
        @(negedge rd_clk);
        apb_req = '0;
    endtask

    task automatic bus_read(input logic [3:0] addr, input logic [31:0] expected);
        logic [31:0] got;
        exp_rdata = expected;
        exp_err   = 1'b0;
        chk_data  = 1'b1;
        chk_err   = 1'b1;
        bus_xfer(1'b0, addr, 32'h0, got);
        chk_data  = 1'b0;
        chk_err   = 1'b0;
    endtask

    task automatic bus_write(input logic [3:0] addr, input logic [31:0] wdata);
        logic [31:0] got;
        exp_err = 1'b0;
        chk_err = 1'b1;
        bus_xfer(1'b1, addr, wdata, got);
        chk_err = 1'b0;
    endtask

    task automatic pop_word();
        logic [31:0] got;
        if (model_q.size() > 0) begin
            exp_rdata = 32'(model_q.pop_front());
            exp_err   = 1'b0;
        end else begin
            exp_rdata = 32'h0;  // Empty FIFO
            exp_err   = 1'b1;
        end
        chk_data = 1'b1;
        chk_err  = 1'b1;
        bus_xfer(1'b0, ADDR_DATA, 32'h0, got);
        chk_data = 1'b0;
        chk_err  = 1'b0;
    endtask

    task automatic push_words(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge wr_clk);
            wr_en   = 1'b1;
            wr_data = DATA_WIDTH'($random(seed));
            if (model_q.size() < FIFO_DEPTH) begin
                model_q.push_back(wr_data);  // A full FIFO drops the word
            end
        end
        @(negedge wr_clk);
        wr_en = 1'b0;
    endtask

    task automatic wait_visible();
        logic [31:0] got;
        int          polls;
        polls = 0;
        got   = 32'h1;
        while (got[0] && polls < 10) begin
            bus_xfer(1'b0, ADDR_STATUS, 32'h0, got);
            polls++;
        end
        assert (!got[0]) else begin
            error_count++;
            $display("FIFO still reads empty after %0d STATUS polls", polls);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (error_count == errs_before) begin
            pass_tests++;
            $display("Test %0d %s: passed", num, name);
        end else begin
            fail_tests++;
            $display("Test %0d %s: %0d errors", num, name, error_count - errs_before);
        end
    endtask

    // ************************************************************
    // Test sequence
    // ************************************************************

    initial begin
        int errs_start;
        int n;
        seed        = 32'hf00a;
        r_rst_n     = 1'b0;
        w_rst_n     = 1'b0;
        wr_en       = 1'b0;
        wr_data     = '0;
        apb_req     = '0;
        exp_rdata   = '0;
        exp_err     = 1'b0;
        chk_data    = 1'b0;
        chk_err     = 1'b0;
        irq_masked  = 1'b0;
        error_count = 0;
        pass_tests  = 0;
        fail_tests  = 0;
        repeat (16) @(negedge rd_clk);
        r_rst_n = 1'b1;
        w_rst_n = 1'b1;

        errs_start = error_count;
        bus_read(ADDR_STATUS, status_word(0));
        bus_read(ADDR_CTRL, 32'h0);
        report_test(1, "reset state", errs_start);

        errs_start = error_count;
        push_words(5);
        wait_visible();
        repeat (5) pop_word();
        report_test(2, "in-order transfer", errs_start);

        errs_start = error_count;
        pop_word();  // Model is empty here
        report_test(3, "empty read", errs_start);

        errs_start = error_count;
        push_words(FIFO_DEPTH);
        assert (full) else begin
            error_count++;
            $display("[FAIL] full: got 0x%h, expected 0x1", full);
        end
        push_words(3);  // All dropped
        fork
            pop_word();
            begin
                do begin
                    @(posedge rd_clk);
                end while (!(apb_req.psel && apb_req.penable));  // Pop edge
                n = 0;
                while (full && n < 3) begin
                    @(posedge wr_clk);
                    @(negedge wr_clk);
                    n++;
                end
                assert (!full) else begin
                    error_count++;
                    $display("[FAIL] full: got 0x%h, expected 0x0 three wr_clk cycles after a pop",
                             full);
                end
            end
        join
        repeat (FIFO_DEPTH - 1) pop_word();
        pop_word();  // Nothing past the first FIFO_DEPTH words
        report_test(4, "full and drop", errs_start);

        errs_start = error_count;
        push_words(6);
        repeat (4) @(negedge rd_clk);
        bus_read(ADDR_STATUS, status_word(6));
        repeat (6) begin
            pop_word();
            bus_read(ADDR_STATUS, status_word(model_q.size()));
        end
        report_test(5, "level", errs_start);

        errs_start = error_count;
        bus_write(ADDR_CTRL, 32'h0001_0014);  // irq_en, threshold 20
        push_words(1);
        n = 0;
        while (!irq && n < IRQ_WAIT) begin
            @(negedge rd_clk);
            n++;
        end
        assert (irq) else begin
            error_count++;
            $display("irq did not rise within %0d rd_clk cycles of the write", IRQ_WAIT);
        end
        bus_read(ADDR_IRQ, 32'h1);
        bus_write(ADDR_IRQ, 32'h1);
        assert (!irq) else begin
            error_count++;
            $display("[FAIL] irq: got 0x%h, expected 0x0", irq);
        end
        pop_word();
        bus_write(ADDR_CTRL, 32'd20);
        irq_masked = 1'b1;
        push_words(1);
        repeat (IRQ_WAIT) @(negedge rd_clk);
        bus_read(ADDR_IRQ, 32'h1);  // Flag sets even while masked
        irq_masked = 1'b0;
        bus_write(ADDR_IRQ, 32'h1);
        bus_write(ADDR_CTRL, 32'h0);
        pop_word();
        report_test(6, "drain timeout", errs_start);

        $display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(TEST_CYCLES * 2 * RD_PERIOD);
        $display("Timeout: the tests were still running after %0d time units",
                 TEST_CYCLES * 2 * RD_PERIOD);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
